/* list.f */
design/memPkg.sv
design/byteRam.sv
design/memCtrl.sv
design/instFetch.sv
design/loadStoreUnit.sv
design/memSubsystem.sv
bench/memSubsystemTb.sv

/* Bender.yml */
package:
  name: mem_subsystem

sources:
  - files:
      - design/memPkg.sv
      - design/byteRam.sv
      - design/memCtrl.sv
      - design/instFetch.sv
      - design/loadStoreUnit.sv
      - design/memSubsystem.sv
  - target: test
    files:
      - bench/memSubsystemTb.sv

/* bench/memSubsystemTb.sv */
`timescale 1ns/1ps

module memSubsystemTb;
    import memPkg::*;

    logic clk = 1'b0;
    logic rst;
    logic rdy;
    logic fetchEn;
    logic instValid;
    logic [xlen-1:0] instWord;
    logic [xlen-1:0] instPc;
    logic lsValid;
    memPkg::lsOp lsOp;
    accessLen lsLen;
    logic lsSigned;
    logic [xlen-1:0] lsAddr;
    logic [xlen-1:0] lsWdata;
    logic lsBusy;
    logic loadValid;
    logic [xlen-1:0] loadData;
    logic storeDone;
    busyCode busy;

    integer seed = 32'hd7a7_d57b;
    int errors = 0;
    int checks = 0;
    int cycle = 0;
    int lastInstCycle = -1;
    logic timingPhase = 1'b0;
    logic stallOn = 1'b0;
    logic rdyAtEdge = 1'b1;
    busyCode busyPrev = busyNone;
    logic [31:0] expPc = resetPc;

    // byte image of what the RAM should hold
    logic [7:0] shadow [4096];
    logic [31:0] expLoads [$];
    string expNames [$];

    memSubsystem #(.addrWidth(12)) memSubsystem_i (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] expectLoad(input logic [7:0] mem [4096],
            input logic [31:0] addr, input accessLen len, input logic sgn);
        logic [31:0] value;
        int n;
        value = '0;
        n = (len == lenByte) ? 1 : ((len == lenHalf) ? 2 : 4);
        for (int k = 0; k < n; k++) begin
            value[8*k +: 8] = mem[(addr + k) & 32'hfff];
        end
        // sign from the top byte of the access
        if (sgn && n == 1) begin
            value = {{24{value[7]}}, value[7:0]};
        end else if (sgn && n == 2) begin
            value = {{16{value[15]}}, value[15:0]};
        end
        return value;
    endfunction

    // four little endian bytes from pc
    function automatic logic [31:0] expectInst(input logic [7:0] mem [4096],
            input logic [31:0] pc);
        return {mem[(pc + 3) & 32'hfff], mem[(pc + 2) & 32'hfff],
                mem[(pc + 1) & 32'hfff], mem[pc & 32'hfff]};
    endfunction

    task automatic finishRun();
        assert (expLoads.size() == 0) else begin
            errors++;
            $display("%0d loads never returned a result", expLoads.size());
        end
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    task automatic abortOnTimeout(input string what);
        errors++;
        $display("timed out after 200 cycles waiting for %s", what);
        finishRun();
    endtask

    task automatic startCmd(input memPkg::lsOp op, input accessLen len, input logic sgn,
            input logic [31:0] addr, input logic [31:0] wdata, input string name);
        int waited;
        int n;
        waited = 0;
        while (lsBusy && waited < 200) begin
            @(negedge clk);
            waited++;
        end
        if (lsBusy) begin
            abortOnTimeout("lsBusy to drop");
        end
        lsValid = 1'b1;
        lsOp = op;
        lsLen = len;
        lsSigned = sgn;
        lsAddr = addr;
        lsWdata = wdata;
        if (op == opStore) begin
            n = (len == lenByte) ? 1 : ((len == lenHalf) ? 2 : 4);
            for (int k = 0; k < n; k++) begin
                shadow[(addr + k) & 32'hfff] = wdata[8*k +: 8];
            end
        end else begin
            expLoads.push_back(expectLoad(shadow, addr, len, sgn));
            expNames.push_back(name);
        end
        @(negedge clk);
        lsValid = 1'b0;
    endtask

    task automatic awaitResult(input memPkg::lsOp op);
        int waited;
        waited = 0;
        while (!(op == opLoad ? loadValid : storeDone) && waited < 200) begin
            @(negedge clk);
            waited++;
        end
        if (!(op == opLoad ? loadValid : storeDone)) begin
            abortOnTimeout(op == opLoad ? "loadValid" : "storeDone");
        end
    endtask

    task automatic runCmd(input memPkg::lsOp op, input accessLen len, input logic sgn,
            input logic [31:0] addr, input logic [31:0] wdata, input string name);
        startCmd(op, len, sgn, addr, wdata, name);
        awaitResult(op);
    endtask

    // data region kept clear of the fetch addresses
    task automatic randomCmd(input string name);
        logic [31:0] addr;
        logic [31:0] data;
        accessLen len;
        addr = 32'h800 + ($unsigned($random(seed)) % 32'h7f0);
        data = $random(seed);
        len = accessLen'($unsigned($random(seed)) % 3);
        if (data[0]) begin
            runCmd(opStore, len, 1'b0, addr, data, name);
        end else begin
            runCmd(opLoad, len, data[1], addr, 32'h0, name);
        end
    endtask

    task automatic countFetches(input int count);
        int waited;
        for (int i = 0; i < count; i++) begin
            waited = 0;
            do begin
                @(negedge clk);
                waited++;
            end while (!instValid && waited < 200);
            if (!instValid) begin
                abortOnTimeout("instValid");
            end
        end
    endtask

    // a fetch already requested still runs after fetchEn drops
    task automatic drainFetch();
        int waited;
        int quiet;
        waited = 0;
        quiet = 0;
        while (quiet < 2 && waited < 200) begin
            @(negedge clk);
            waited++;
            quiet = (busy == busyNone) ? quiet + 1 : 0;
        end
        if (quiet < 2) begin
            abortOnTimeout("the last fetch to finish");
        end
    endtask

    always @(posedge clk) begin
        rdyAtEdge <= rdy;
    end

    // random rdy stretches decided at posedge and driven at negedge
    initial begin
        int left;
        int draw;
        logic on;
        left = 0;
        forever begin
            @(posedge clk);
            draw = $random(seed);
            on = stallOn;
            @(negedge clk);
            if (!on) begin
                rdy = 1'b1;
                left = 0;
            end else if (left > 0) begin
                rdy = 1'b0;
                left--;
            end else if (draw[1:0] == 2'b00) begin
                rdy = 1'b0;
                left = draw[4:2] % 6;
            end else begin
                rdy = 1'b1;
            end
        end
    end

    always @(negedge clk) begin
        logic [31:0] want;
        string name;
        if (!rst) begin
            if (!rdyAtEdge) begin
                checks++;
                assert (!loadValid && !storeDone && !instValid) else begin
                    errors++;
                    $display("a result pulse came out while rdy was low");
                end
                assert (busy == busyPrev) else begin
                    errors++;
                    $display("ERROR stallBusy expected %0d actual %0d", busyPrev, busy);
                end
            end
            if (loadValid) begin
                assert (expLoads.size() != 0) else begin
                    errors++;
                    $display("loadValid pulsed with no load outstanding");
                end
                if (expLoads.size() != 0) begin
                    want = expLoads.pop_front();
                    name = expNames.pop_front();
                    checks++;
                    assert (loadData === want) else begin
                        errors++;
                        $display("ERROR %s expected %h actual %h", name, want, loadData);
                    end
                end
            end
            if (instValid) begin
                checks++;
                want = expectInst(shadow, expPc);
                assert (instPc === expPc) else begin
                    errors++;
                    $display("ERROR fetchPc expected %h actual %h", expPc, instPc);
                end
                assert (instWord === want) else begin
                    errors++;
                    $display("ERROR fetchWord expected %h actual %h", want, instWord);
                end
                // grant to grant is five stages plus the idle cycle
                if (timingPhase && lastInstCycle >= 0) begin
                    assert (cycle - lastInstCycle == 6) else begin
                        errors++;
                        $display("ERROR fetchGap expected %0d actual %0d", 6,
                            cycle - lastInstCycle);
                    end
                end
                lastInstCycle = timingPhase ? cycle : -1;
                expPc = expPc + 32'd4;
            end
        end
        busyPrev = busy;
        cycle++;
    end

    initial begin
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] signedVal;
        accessLen len;
        rst = 1'b1;
        rdy = 1'b1;
        fetchEn = 1'b0;
        lsValid = 1'b0;
        lsOp = opLoad;
        lsLen = lenByte;
        lsSigned = 1'b0;
        lsAddr = '0;
        lsWdata = '0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        checks++;
        assert (busy == busyNone && !instValid && !loadValid && !storeDone && !lsBusy)
        else begin
            errors++;
            $display("outputs were not idle after reset");
        end

        // fill the whole RAM through the data port
        for (int a = 0; a < 4096; a += 4) begin
            runCmd(opStore, lenWord, 1'b0, a, $random(seed), "preload");
        end

        for (int i = 0; i < 40; i++) begin
            addr = $random(seed);
            data = $random(seed);
            len = accessLen'($unsigned($random(seed)) % 3);
            runCmd(opStore, len, 1'b0, addr, data, "store");
            runCmd(opLoad, len, data[31], addr, 32'h0, "storeThenLoad");
        end
        runCmd(opStore, lenWord, 1'b0, 32'hffff_fffe, 32'h1234_5678, "wrapStore");
        runCmd(opLoad, lenWord, 1'b0, 32'hffff_fffe, 32'h0, "wrapLoad");

        // with the top bit set signed and unsigned results differ only above the access
        for (int i = 0; i < 8; i++) begin
            addr = $random(seed);
            data = $random(seed) | 32'h0000_8080;
            len = i[0] ? lenHalf : lenByte;
            runCmd(opStore, len, 1'b0, addr, data, "negStore");
            runCmd(opLoad, len, 1'b1, addr, 32'h0, "signedLoad");
            signedVal = loadData;
            runCmd(opLoad, len, 1'b0, addr, 32'h0, "unsignedLoad");
            checks++;
            assert ((signedVal ^ loadData) == (len == lenByte ? 32'hffff_ff00 : 32'hffff_0000))
            else begin
                errors++;
                $display("ERROR extension expected %h actual %h",
                    len == lenByte ? 32'hffff_ff00 : 32'hffff_0000, signedVal ^ loadData);
            end
        end

        timingPhase = 1'b1;
        fetchEn = 1'b1;
        countFetches(16);
        @(negedge clk);
        timingPhase = 1'b0;

        for (int i = 0; i < 30; i++) begin
            randomCmd("sharedLoad");
        end

        stallOn = 1'b1;
        for (int i = 0; i < 30; i++) begin
            randomCmd("stalledLoad");
        end
        countFetches(4);
        stallOn = 1'b0;
        fetchEn = 1'b0;
        drainFetch();

        // second command arrives while busy and must be dropped
        addr = 32'h0000_0c40;
        startCmd(opStore, lenWord, 1'b0, addr, 32'hcafe_f00d, "keptStore");
        checks++;
        assert (lsBusy) else begin
            errors++;
            $display("lsBusy stayed low after a command was accepted");
        end
        lsValid = 1'b1;
        lsOp = opStore;
        lsLen = lenWord;
        lsAddr = addr;
        lsWdata = 32'h0bad_0bad;
        @(negedge clk);
        lsValid = 1'b0;
        awaitResult(opStore);
        runCmd(opLoad, lenWord, 1'b0, addr, 32'h0, "afterIgnored");
        repeat (4) @(negedge clk);
        finishRun();
    end

endmodule

/* design/memSubsystem.sv */
`timescale 1ns/1ps

module memSubsystem #(
    parameter int addrWidth = 12
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    rdy,

    // fetch side
    input  logic                    fetchEn,
    output logic                    instValid,
    output logic [memPkg::xlen-1:0] instWord,
    output logic [memPkg::xlen-1:0] instPc,

    // data side
    input  logic                    lsValid,
    input  memPkg::lsOp             lsOp,
    input  memPkg::accessLen        lsLen,
    input  logic                    lsSigned,
    input  logic [memPkg::xlen-1:0] lsAddr,
    input  logic [memPkg::xlen-1:0] lsWdata,
    output logic                    lsBusy,
    output logic                    loadValid,
    output logic [memPkg::xlen-1:0] loadData,
    output logic                    storeDone,

    output memPkg::busyCode         busy
);
    import memPkg::*;

    // fetch unit to controller
    logic instReq;
    logic [xlen-1:0] pc;
    logic instDone;
    logic [xlen-1:0] inst;

    // load/store unit to controller
    logic dataReq;
    memPkg::lsOp dataOp;
    accessLen dataLen;
    logic [xlen-1:0] dataAddr;
    logic [xlen-1:0] dataWrite;
    logic dataDone;
    logic [xlen-1:0] dataRead;

    // controller to RAM
    logic [xlen-1:0] memAddr;
    logic memWe;
    logic [byteWidth-1:0] memWdata;
    logic [byteWidth-1:0] memRdata;

    byteRam #(
        .addrWidth(addrWidth)
    ) byteRam_i (
        .clk   (clk),
        .addr  (memAddr[addrWidth-1:0]),
        .we    (memWe),
        .wdata (memWdata),
        .rdata (memRdata)
    );

    memCtrl memCtrl_i (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .instReq   (instReq),
        .pc        (pc),
        .instDone  (instDone),
        .inst      (inst),
        .dataReq   (dataReq),
        .dataOp    (dataOp),
        .dataLen   (dataLen),
        .dataAddr  (dataAddr),
        .dataWrite (dataWrite),
        .dataDone  (dataDone),
        .dataRead  (dataRead),
        .memAddr   (memAddr),
        .memWe     (memWe),
        .memWdata  (memWdata),
        .memRdata  (memRdata),
        .busy      (busy)
    );

    instFetch instFetch_i (
        .clk       (clk),
        .rst       (rst),
        .fetchEn   (fetchEn),
        .instReq   (instReq),
        .pc        (pc),
        .instDone  (instDone),
        .inst      (inst),
        .instValid (instValid),
        .instWord  (instWord),
        .instPc    (instPc)
    );

    loadStoreUnit loadStoreUnit_i (
        .clk       (clk),
        .rst       (rst),
        .lsValid   (lsValid),
        .lsOp      (lsOp),
        .lsLen     (lsLen),
        .lsSigned  (lsSigned),
        .lsAddr    (lsAddr),
        .lsWdata   (lsWdata),
        .lsBusy    (lsBusy),
        .dataReq   (dataReq),
        .dataOp    (dataOp),
        .dataLen   (dataLen),
        .dataAddr  (dataAddr),
        .dataWrite (dataWrite),
        .dataDone  (dataDone),
        .dataRead  (dataRead),
        .loadValid (loadValid),
        .loadData  (loadData),
        .storeDone (storeDone)
    );

endmodule

/* design/loadStoreUnit.sv */
`timescale 1ns/1ps

module loadStoreUnit (
    input  logic                    clk,
    input  logic                    rst,

    // command side
    input  logic                    lsValid,
    input  memPkg::lsOp             lsOp,
    input  memPkg::accessLen        lsLen,
    input  logic                    lsSigned,
    input  logic [memPkg::xlen-1:0] lsAddr,
    input  logic [memPkg::xlen-1:0] lsWdata,
    output logic                    lsBusy,

    // controller side
    output logic                    dataReq,
    output memPkg::lsOp             dataOp,
    output memPkg::accessLen        dataLen,
    output logic [memPkg::xlen-1:0] dataAddr,
    output logic [memPkg::xlen-1:0] dataWrite,
    input  logic                    dataDone,
    input  logic [memPkg::xlen-1:0] dataRead,

    // results
    output logic                    loadValid,
    output logic [memPkg::xlen-1:0] loadData,
    output logic                    storeDone
);
    import memPkg::*;

    logic pending;
    logic signedReg;
    logic accept;
    logic [xlen-1:0] extended;

    assign accept = lsValid && !pending;
    assign dataReq = pending;
    assign lsBusy = pending;

    // dataRead is already zero above the access length
    always_comb begin
        extended = dataRead;
        if (signedReg) begin
            case (dataLen)
                lenByte: extended = {{(xlen - 8){dataRead[7]}}, dataRead[7:0]};
                lenHalf: extended = {{(xlen - 16){dataRead[15]}}, dataRead[15:0]};
                default: extended = dataRead;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending   <= 1'b0;
            loadValid <= 1'b0;
            storeDone <= 1'b0;
        end else begin
            loadValid <= dataDone && (dataOp == opLoad);
            storeDone <= dataDone && (dataOp == opStore);
            if (dataDone) begin
                pending <= 1'b0;
            end else if (accept) begin
                pending <= 1'b1;
            end
        end
    end

    // command held toward the controller until dataDone
    always_ff @(posedge clk) begin
        if (accept) begin
            dataOp    <= lsOp;
            dataLen   <= lsLen;
            dataAddr  <= lsAddr;
            dataWrite <= lsWdata;
            signedReg <= lsSigned;
        end
    end

    always_ff @(posedge clk) begin
        if (dataDone && dataOp == opLoad) begin
            loadData <= extended;
        end
    end

endmodule

/* design/instFetch.sv */
`timescale 1ns/1ps

module instFetch (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    fetchEn,

    // controller side
    output logic                    instReq,
    output logic [memPkg::xlen-1:0] pc,
    input  logic                    instDone,
    input  logic [memPkg::xlen-1:0] inst,

    // fetched instruction out
    output logic                    instValid,
    output logic [memPkg::xlen-1:0] instWord,
    output logic [memPkg::xlen-1:0] instPc
);
    import memPkg::*;

    // a requested fetch runs to completion even if fetchEn drops
    logic pending;

    assign instReq = fetchEn || pending;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending   <= 1'b0;
            instValid <= 1'b0;
            pc        <= resetPc;
        end else begin
            instValid <= instDone;
            if (instDone) begin
                pending <= 1'b0;
                pc      <= pc + xlen'(4);
            end else if (fetchEn) begin
                pending <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (instDone) begin
            instWord <= inst;
            instPc   <= pc;
        end
    end

endmodule

/* design/memCtrl.sv */
`timescale 1ns/1ps

module memCtrl (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         rdy,

    // fetch client
    input  logic                         instReq,
    input  logic [memPkg::xlen-1:0]      pc,
    output logic                         instDone,
    output logic [memPkg::xlen-1:0]      inst,

    // load/store client
    input  logic                         dataReq,
    input  memPkg::lsOp                  dataOp,
    input  memPkg::accessLen             dataLen,
    input  logic [memPkg::xlen-1:0]      dataAddr,
    input  logic [memPkg::xlen-1:0]      dataWrite,
    output logic                         dataDone,
    output logic [memPkg::xlen-1:0]      dataRead,

    // RAM side
    output logic [memPkg::xlen-1:0]      memAddr,
    output logic                         memWe,
    output logic [memPkg::byteWidth-1:0] memWdata,
    input  logic [memPkg::byteWidth-1:0] memRdata,

    output memPkg::busyCode              busy
);
    import memPkg::*;

    // control state
    busyCode owner;
    logic [2:0] stage;

    // access latched at grant
    logic [xlen-1:0] base;
    lsOp op;
    accessLen len;
    logic [xlen-1:0] assembly;

    logic [2:0] byteCount;
    logic [2:0] addrStep;
    logic [1:0] rdLane;
    logic [xlen-1:0] merged;
    logic reading;
    logic lastStage;
    logic finish;

    always_comb begin
        case (len)
            lenByte: byteCount = 3'd1;
            lenHalf: byteCount = 3'd2;
            default: byteCount = 3'd4;
        endcase
    end

    assign reading = (owner == busyInst) || (owner == busyData && op == opLoad);

    // loads and fetches finish one stage after the last address,
    // stores finish on the last write
    always_comb begin
        case (owner)
            busyInst: lastStage = (stage == 3'd4);
            busyData: begin
                if (op == opStore) begin
                    lastStage = (stage == byteCount - 3'd1);
                end else begin
                    lastStage = (stage == byteCount);
                end
            end
            default: lastStage = 1'b0;
        endcase
    end

    assign finish = rdy && lastStage;
    assign instDone = finish && (owner == busyInst);
    assign dataDone = finish && (owner == busyData);

    // byte arriving now belongs to the address of the previous stage
    assign rdLane = stage[1:0] - 2'd1;

    // last byte goes straight to the client on the done cycle
    assign merged = assembly
        | ({{(xlen - byteWidth){1'b0}}, memRdata} << (rdLane * byteWidth));

    assign inst = merged;
    assign dataRead = merged;

    // while stalled keep presenting the previous address, so the byte
    // still owed to the assembly register is there when rdy returns
    assign addrStep = rdy ? stage : stage - 3'd1;
    assign memAddr = base + {{(xlen - 3){1'b0}}, addrStep};

    assign memWe = rdy && (owner == busyData) && (op == opStore);
    assign memWdata = dataWrite[stage[1:0] * byteWidth +: byteWidth];

    assign busy = owner;

    // owner and stage counter
    always_ff @(posedge clk) begin
        if (rst) begin
            owner <= busyNone;
            stage <= 3'd0;
        end else if (rdy) begin
            if (owner == busyNone) begin
                stage <= 3'd0;
                // data wins over fetch, decided only here
                if (dataReq) begin
                    owner <= busyData;
                end else if (instReq) begin
                    owner <= busyInst;
                end
            end else if (lastStage) begin
                owner <= busyNone;
                stage <= 3'd0;
            end else begin
                stage <= stage + 3'd1;
            end
        end
    end

    // access parameters and byte collection
    always_ff @(posedge clk) begin
        if (rdy) begin
            if (owner == busyNone) begin
                assembly <= '0;
                if (dataReq) begin
                    base <= dataAddr;
                    op   <= dataOp;
                    len  <= dataLen;
                end else begin
                    base <= pc;
                    op   <= opLoad;
                    len  <= lenWord;
                end
            end else if (reading && stage != 3'd0) begin
                assembly[rdLane * byteWidth +: byteWidth] <= memRdata;
            end
        end
    end

endmodule

/* design/byteRam.sv */
`timescale 1ns/1ps

module byteRam #(
    parameter int addrWidth = 12
) (
    input  logic                         clk,
    input  logic [addrWidth-1:0]         addr,
    input  logic                         we,
    input  logic [memPkg::byteWidth-1:0] wdata,
    output logic [memPkg::byteWidth-1:0] rdata
);
    import memPkg::*;

    localparam int depth = 2 ** addrWidth;

    logic [byteWidth-1:0] mem [depth];

    // write at the edge
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // registered read, the controller counts on exactly one cycle here
    always_ff @(posedge clk) begin
        rdata <= mem[addr];
    end

endmodule

/* design/memPkg.sv */
package memPkg;

    // core data path width
    localparam int xlen = 32;

    // one RAM word
    localparam int byteWidth = 8;

    // number of bytes moved by a data access
    typedef enum logic [1:0] {
        lenByte = 2'd0,
        lenHalf = 2'd1,
        lenWord = 2'd2
    } accessLen;

    typedef enum logic {
        opLoad  = 1'b0,
        opStore = 1'b1
    } lsOp;

    // which client currently owns the RAM
    typedef enum logic [1:0] {
        busyNone = 2'd0,
        busyData = 2'd1,
        busyInst = 2'd2
    } busyCode;

    // first fetch address after reset
    localparam logic [xlen-1:0] resetPc = 32'h0000_0000;

endpackage
